/* Makefile */
# Verilator build and run for the tone generator testbench.

VERILATOR ?= verilator
TOP       ?= tb_synth_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output.
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* audio_pkg.sv */
`default_nettype none

package audio_pkg;

    // ========================================
    // Voice count and sample formats
    // ========================================

    localparam int NUM_VOICES = 4; // Mixer adder is written for four voices.

    typedef logic signed [15:0] sample_t;   // One audio sample.
    typedef logic signed [19:0] mix_sum_t;  // Sum of all voices with headroom.

    // Voice 3 in the top bits, voice 0 at the bottom.
    typedef struct packed {
        sample_t voice3;
        sample_t voice2;
        sample_t voice1;
        sample_t voice0;
    } sample_vec_t;

    localparam sample_t SQUARE_AMP = 16'sh2000; // Square wave peak.

endpackage

`default_nettype wire

/* polyphony_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

module polyphony_mixer
    import audio_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [7:0]  attenuation,   // 0 is full level.
    input  wire sample_vec_t voices,
    input  wire logic        samples_ready,
    output sample_t          sample,
    output logic             sample_ready
);

    localparam logic [2:0] MIXER_LAST = 3'd7; // Result ready in this state.
    localparam int         PROD_W     = 29;   // 9-bit by 20-bit signed product.

    mix_sum_t                 sum_next;
    mix_sum_t                 sum_r;
    mix_sum_t                 shift_r;
    logic [7:0]               atten_r;
    logic signed [PROD_W-1:0] prod_r;
    logic signed [PROD_W-1:0] diff;
    logic [2:0]               state;
    logic                     accept;

    // ========================================
    // Control
    // ========================================

    assign accept = samples_ready && (state == 3'd0); // Busy strobes are dropped.

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= 3'd0;
            sample_ready <= 1'b0;
        end else begin
            sample_ready <= (state == MIXER_LAST); // Eight cycles after accept.
            if (state == 3'd0) begin
                if (accept) begin
                    state <= 3'd1;
                end
            end else begin
                state <= state + 3'd1; // State 7 wraps back to idle.
            end
        end
    end

    // ========================================
    // Arithmetic pipeline
    // ========================================

    // Sign-extended sum of all four voices.
    assign sum_next = mix_sum_t'(voices.voice0) + mix_sum_t'(voices.voice1)
                    + mix_sum_t'(voices.voice2) + mix_sum_t'(voices.voice3);

    assign diff = PROD_W'(sum_r) - prod_r;

    // Stage 1. Sum and attenuation held for the whole pass.
    always_ff @(posedge clk) begin
        if (accept) begin
            sum_r   <= sum_next;
            atten_r <= attenuation;
        end
    end

    // Stages 2 and 3 run freely off the held operands.
    always_ff @(posedge clk) begin
        shift_r <= sum_r >>> 8; // Sum over 256.
        prod_r  <= PROD_W'($signed({1'b0, atten_r})) * PROD_W'(shift_r);
    end

    // Stage 4. Output updates only with the strobe.
    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
        end else if (state == MIXER_LAST) begin
            sample <= diff[15:0]; // Truncated to 16 bits.
        end
    end

endmodule

`default_nettype wire

/* pwm_dac.sv */
`timescale 1ns/100ps
`default_nettype none

module pwm_dac
    import audio_pkg::*;
#(
    parameter int PWM_BITS = 8 // Frame is 2^PWM_BITS cycles.
) (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire sample_t sample,
    input  wire logic    sample_ready,
    output logic         pwm_out
);

    localparam int                  SAMPLE_W  = $bits(sample_t);
    localparam logic [PWM_BITS-1:0] SIGN_FLIP = PWM_BITS'(1) << (PWM_BITS - 1);
    localparam logic [PWM_BITS-1:0] CNT_LAST  = '1;

    sample_t             latest;
    sample_t             sample_r;
    logic [PWM_BITS-1:0] frame_cnt;
    logic [PWM_BITS-1:0] duty;
    logic [PWM_BITS-1:0] duty_next;

    assign latest    = sample_ready ? sample : sample_r; // Newest value wins.
    assign duty_next = latest[SAMPLE_W-1 -: PWM_BITS] ^ SIGN_FLIP; // Offset binary.

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_cnt <= '0;
            duty      <= '0;
            sample_r  <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1; // Free running.
            if (sample_ready) begin
                sample_r <= sample;
            end
            // Duty only changes between frames.
            if (frame_cnt == CNT_LAST) begin
                duty <= duty_next;
            end
        end
    end

    assign pwm_out = (frame_cnt < duty);

endmodule

`default_nettype wire

/* synth_top.sv */
`timescale 1ns/100ps
`default_nettype none

module synth_top
    import audio_pkg::*;
    import voice_pkg::*;
#(
    parameter int SAMPLE_DIV = 16, // At least 9 so the mixer keeps up.
    parameter int PWM_BITS   = 8
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire note_cmd_t  note_cmd,
    input  wire logic       note_cmd_valid,
    input  wire logic [7:0] attenuation,
    output sample_t         sample,
    output logic            sample_ready,
    output logic            pwm_out
);

    sample_vec_t voices;
    logic        samples_ready;

    voice_bank #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) bank_i (
        .clk            (clk),
        .reset          (reset),
        .note_cmd       (note_cmd),
        .note_cmd_valid (note_cmd_valid),
        .voices         (voices),
        .samples_ready  (samples_ready)
    );

    polyphony_mixer mixer_i (
        .clk           (clk),
        .reset         (reset),
        .attenuation   (attenuation),
        .voices        (voices),
        .samples_ready (samples_ready),
        .sample        (sample),
        .sample_ready  (sample_ready)
    );

    // Mixed sample also drives the 1-bit output.
    pwm_dac #(
        .PWM_BITS (PWM_BITS)
    ) dac_i (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_ready (sample_ready),
        .pwm_out      (pwm_out)
    );

endmodule

`default_nettype wire

/* tb.f */
audio_pkg.sv
voice_pkg.sv
voice_osc.sv
voice_bank.sv
polyphony_mixer.sv
pwm_dac.sv
synth_top.sv
tb_synth_top.sv

/* tb_synth_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_synth_top
    import audio_pkg::*;
    import voice_pkg::*;
();

    localparam int SAMPLE_DIV  = 16;
    localparam int PWM_BITS    = 8;
    localparam int PWM_FRAME   = 1 << PWM_BITS;
    localparam int RESULT_WAIT = 2 * SAMPLE_DIV + 8; // Longest gap between two results.

    // ========================================
    // Run length and timeout
    // ========================================

    // 34 mixer results plus the PWM frames of the duty test.
    localparam int RESULT_COUNT    = 34;
    localparam int EXPECTED_CYCLES = RESULT_COUNT * SAMPLE_DIV + 4 * PWM_FRAME + 64;
    // Twelvefold margin rounded up to whole thousands.
    localparam int MAX_CYCLES      = ((12 * EXPECTED_CYCLES + 999) / 1000) * 1000;

    logic       clk;
    logic       reset;
    note_cmd_t  note_cmd;
    logic       note_cmd_valid;
    logic [7:0] attenuation;
    sample_t    sample;
    logic       sample_ready;
    logic       pwm_out;

    int          cycle_count;
    int          error_count;
    int          pass_count;
    int          fail_count;
    logic [31:0] rng_state;

    // Reference model of the voices as it stands before the next tick.
    phase_t      model_phase [NUM_VOICES];
    phase_t      model_step  [NUM_VOICES];
    waveform_t   model_wave  [NUM_VOICES];
    logic        model_key   [NUM_VOICES];
    logic [7:0]  model_atten;

    synth_top #(
        .SAMPLE_DIV (SAMPLE_DIV),
        .PWM_BITS   (PWM_BITS)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .note_cmd       (note_cmd),
        .note_cmd_valid (note_cmd_valid),
        .attenuation    (attenuation),
        .sample         (sample),
        .sample_ready   (sample_ready),
        .pwm_out        (pwm_out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period.

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ========================================
    // Model and helpers
    // ========================================

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223; // LCG step.
        return rng_state;
    endfunction

    function automatic int voice_value(input int v);
        int value;
        value = 0;
        if (model_key[v]) begin
            if (model_wave[v] == WAVE_SQUARE) begin
                value = model_phase[v][15] ? -int'(SQUARE_AMP) : int'(SQUARE_AMP);
            end else begin
                value = int'(model_phase[v]) - 32768; // Saw centred on zero.
            end
        end
        return value;
    endfunction

    function automatic logic [15:0] expected_mix();
        int sum;
        int shifted;
        int diff;
        sum = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            sum += voice_value(v);
        end
        shifted = sum >>> 8;
        diff    = sum - int'(model_atten) * shifted;
        return 16'(diff); // Low 16 bits only.
    endfunction

    task automatic advance_model();
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (model_key[v]) begin
                model_phase[v] = model_phase[v] + model_step[v]; // Wraps at 2^16.
            end
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    // One-cycle command issued right after a result so it lands before the next tick.
    task automatic send_note(input int v, input logic key, input waveform_t wave,
                             input phase_t step);
        note_cmd.voice    = voice_idx_t'(v);
        note_cmd.key_on   = key;
        note_cmd.waveform = wave;
        note_cmd.step     = step;
        note_cmd_valid    = 1'b1;
        @(posedge clk);
        #1;
        note_cmd_valid = 1'b0;
        model_key[v] = key;
        if (key) begin
            model_phase[v] = '0;
            model_step[v]  = step;
            model_wave[v]  = wave;
        end
    endtask

    task automatic set_attenuation(input logic [7:0] value);
        attenuation = value; // Used from the next accepted strobe.
        model_atten = value;
    endtask

    // Waits for the next mixer result, compares it and steps the model.
    task automatic next_result(input string name);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!sample_ready && waited < RESULT_WAIT);
        assert (sample_ready) else begin
            $display("%s: sample_ready did not arrive within %0d cycles", name, RESULT_WAIT);
            error_count++;
        end
        if (sample_ready) begin
            check_value(name, int'($signed(expected_mix())), int'(sample));
            advance_model();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("[PASS] %s", name);
            pass_count++;
        end else begin
            $display("[FAIL] %s with %0d errors", name, error_count - errors_before);
            fail_count++;
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic reset_state_test();
        int errors_before;
        errors_before = error_count;
        repeat (10) begin
            check_value("reset_state sample_ready", 0, int'(sample_ready));
            check_value("reset_state pwm_out", 0, int'(pwm_out));
            check_value("reset_state sample", 0, int'(sample));
            @(posedge clk);
            #1;
        end
        finish_test("reset_state", errors_before);
    endtask

    task automatic single_saw_test();
        int     errors_before;
        phase_t step;
        errors_before = error_count;
        next_result("single_saw"); // Align with the tick.
        step = 16'h2000 | phase_t'(next_random() >> 19); // Ten steps pass the wrap.
        set_attenuation(8'd0);
        send_note(0, 1'b1, WAVE_SAW, step);
        repeat (10) next_result("single_saw");
        finish_test("single_saw", errors_before);
    endtask

    task automatic four_voice_mix_test();
        int errors_before;
        errors_before = error_count;
        set_attenuation(8'd0);
        for (int v = 0; v < NUM_VOICES; v++) begin
            send_note(v, 1'b1, v[0] ? WAVE_SQUARE : WAVE_SAW, phase_t'(next_random() >> 16));
        end
        repeat (10) next_result("four_voice_mix");
        finish_test("four_voice_mix", errors_before);
    endtask

    task automatic attenuation_test();
        int         errors_before;
        logic [7:0] levels [4];
        errors_before = error_count;
        levels[0] = 8'd64;
        levels[1] = 8'd128;
        levels[2] = 8'd255;
        levels[3] = 8'(next_random() >> 24);
        foreach (levels[i]) begin
            set_attenuation(levels[i]);
            next_result("attenuation");
            next_result("attenuation"); // Second pass at the same level.
        end
        finish_test("attenuation", errors_before);
    endtask

    task automatic key_off_test();
        int errors_before;
        errors_before = error_count;
        set_attenuation(8'd0);
        for (int v = 0; v < NUM_VOICES; v++) begin
            send_note(v, 1'b0, WAVE_SAW, '0);
            next_result("key_off");
        end
        check_value("key_off final", 0, int'(sample)); // All voices silent.
        finish_test("key_off", errors_before);
    endtask

    task automatic pwm_duty_test();
        int          errors_before;
        int          high_cycles;
        int          expected_duty;
        logic [15:0] level;
        errors_before = error_count;
        set_attenuation(8'd0);
        send_note(0, 1'b1, WAVE_SQUARE, '0); // Step 0 holds the level.
        next_result("pwm_duty");
        level         = expected_mix();
        expected_duty = (int'($signed(level)) + 32768) >> (16 - PWM_BITS);
        repeat (2 * PWM_FRAME) @(posedge clk);
        #1;
        high_cycles = 0;
        repeat (PWM_FRAME) begin
            if (pwm_out) begin
                high_cycles++;
            end
            @(posedge clk);
            #1;
        end
        check_value("pwm_duty", expected_duty, high_cycles);
        finish_test("pwm_duty", errors_before);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        reset          = 1'b1;
        note_cmd       = '0;
        note_cmd_valid = 1'b0;
        attenuation    = 8'd0;
        cycle_count    = 0;
        error_count    = 0;
        pass_count     = 0;
        fail_count     = 0;
        rng_state      = 32'h190c;
        model_atten    = 8'd0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            model_phase[v] = '0;
            model_step[v]  = '0;
            model_wave[v]  = WAVE_SAW;
            model_key[v]   = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_state_test();
        single_saw_test();
        four_voice_mix_test();
        attenuation_test();
        key_off_test();
        pwm_duty_test();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* voice_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_bank
    import audio_pkg::*;
    import voice_pkg::*;
#(
    parameter int SAMPLE_DIV = 16 // Clock cycles per sample period.
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire note_cmd_t note_cmd,
    input  wire logic      note_cmd_valid,
    output sample_vec_t    voices,
    output logic           samples_ready
);

    // ========================================
    // Sample tick divider
    // ========================================

    localparam int               CNT_W    = $clog2(SAMPLE_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAMPLE_DIV - 1);

    logic [CNT_W-1:0] div_cnt;
    logic             tick;
    sample_t          osc_sample [NUM_VOICES];

    assign tick = (div_cnt == CNT_LAST); // Last cycle of the period.

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt       <= '0;
            samples_ready <= 1'b0;
        end else begin
            div_cnt       <= tick ? '0 : div_cnt + 1'b1;
            samples_ready <= tick; // High with the new samples.
        end
    end

    // ========================================
    // Command decode and oscillators
    // ========================================

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        logic load;

        // One load per voice, picked by the command's index.
        assign load = note_cmd_valid && (note_cmd.voice == voice_idx_t'(i));

        voice_osc osc_i (
            .clk      (clk),
            .reset    (reset),
            .tick     (tick),
            .load     (load),
            .key_on   (note_cmd.key_on),
            .waveform (note_cmd.waveform),
            .step     (note_cmd.step),
            .sample   (osc_sample[i])
        );
    end

    // Gather the voices into the bus struct.
    always_comb begin
        voices.voice0 = osc_sample[0];
        voices.voice1 = osc_sample[1];
        voices.voice2 = osc_sample[2];
        voices.voice3 = osc_sample[3];
    end

endmodule

`default_nettype wire

/* voice_osc.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_osc
    import audio_pkg::*;
    import voice_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      tick,     // One pulse per sample period.
    input  wire logic      load,     // Note command for this voice.
    input  wire logic      key_on,
    input  wire waveform_t waveform,
    input  wire phase_t    step,
    output sample_t        sample
);

    phase_t    step_r;
    waveform_t wave_r;
    logic      key_r;
    phase_t    phase_r;

    // Voice state with any command of this cycle applied.
    logic      key_eff;
    phase_t    step_eff;
    waveform_t wave_eff;
    phase_t    phase_eff;
    sample_t   shaped;

    // A command lands before a tick of the same cycle.
    always_comb begin
        key_eff   = key_r;
        step_eff  = step_r;
        wave_eff  = wave_r;
        phase_eff = phase_r;
        if (load) begin
            key_eff = key_on; // Key off keeps phase, step and waveform.
            if (key_on) begin
                step_eff  = step;
                wave_eff  = waveform;
                phase_eff = '0; // Restart the cycle.
            end
        end
    end

    // Waveform shaper.
    always_comb begin
        if (wave_eff == WAVE_SQUARE) begin
            shaped = phase_eff[PHASE_W-1] ? -SQUARE_AMP : SQUARE_AMP;
        end else begin
            shaped = sample_t'(phase_eff - 16'h8000); // Saw centred on zero.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            key_r  <= 1'b0;
            sample <= '0;
        end else begin
            key_r <= key_eff;
            if (tick) begin
                sample <= key_eff ? shaped : '0; // Released voice is silent.
            end
        end
    end

    always_ff @(posedge clk) begin
        step_r  <= step_eff;
        wave_r  <= wave_eff;
        phase_r <= (tick && key_eff) ? phase_eff + step_eff : phase_eff; // Wraps mod 2^16.
    end

endmodule

`default_nettype wire

/* voice_pkg.sv */
`default_nettype none

package voice_pkg;

    // ========================================
    // Voice control types
    // ========================================

    localparam int PHASE_W = 16;

    typedef logic [PHASE_W-1:0] phase_t; // Phase and phase step.
    typedef logic [1:0]         voice_idx_t;

    typedef enum logic {
        WAVE_SAW    = 1'b0,
        WAVE_SQUARE = 1'b1
    } waveform_t;

    // Note command, 20 bits.
    typedef struct packed {
        voice_idx_t voice;    // Target voice.
        logic       key_on;   // Zero releases the voice.
        waveform_t  waveform;
        phase_t     step;     // Phase step per sample.
    } note_cmd_t;

endpackage

`default_nettype wire
